// File: Makefile
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/stage_reg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/hazard_unit.sv
logic/regfile.sv
logic/execute_unit.sv
logic/lsu.sv
logic/rv_core.sv
sim/tb_rv_core.sv

// File: logic/core_pkg.sv
/*
 Pipeline types: ALU op codes, decode forward selects and the
 payload carried by each stage register. All-zero payload is a bubble.
*/
package core_pkg;
    import rv_isa_pkg::*;

    // ALU_ADD must stay zero so a cleared payload is a harmless add
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        FWD_RF, FWD_EX, FWD_MEM, FWD_LOAD
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  wreg;
        logic                  load;
        logic                  store;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wreg;
        logic                  load;
        logic                  store;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       wdata;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wreg;
    } mem_wb_t;

endpackage

// File: logic/decoder.sv
/*
 Decode stage logic. Branches resolve here on the forwarded operands,
 so i_rs1_val/i_rs2_val must already be bypassed. Unknown opcodes
 decode as a no-op with no register write.
*/
`timescale 1ns/1ns

module decoder import rv_isa_pkg::*, core_pkg::*; (
    input  logic [31:0]           i_instr,
    input  logic [XLEN-1:0]       i_pc,
    input  logic [XLEN-1:0]       i_rs1_val,
    input  logic [XLEN-1:0]       i_rs2_val,
    output id_ex_t                o_ctrl,
    output logic [XLEN-1:0]       o_imm,
    output logic [REG_ADDR_W-1:0] o_rs1,
    output logic [REG_ADDR_W-1:0] o_rs2,
    output logic                  o_uses_rs1,
    output logic                  o_uses_rs2,
    output logic                  o_branch_taken,
    output logic [XLEN-1:0]       o_branch_target
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
    alu_op_e         f3_op;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[F3_LSB +: 3];
    // bit 30 picks sub / sra
    assign alt    = (i_instr[F7_LSB +: 7] == F7_ALT);
    assign o_rs1  = i_instr[RS1_LSB +: REG_ADDR_W];
    assign o_rs2  = i_instr[RS2_LSB +: REG_ADDR_W];

    // immediate formats
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    // funct3 to alu op, shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB: f3_op = ALU_ADD;
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SRL_SRA: f3_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            default:    f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_ctrl         = '0;
        o_ctrl.rd      = i_instr[RD_LSB +: REG_ADDR_W];
        o_imm          = imm_i;
        o_uses_rs1     = 1'b0;
        o_uses_rs2     = 1'b0;
        o_branch_taken = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_ctrl.wreg   = 1'b1;
                // only register form has sub
                o_ctrl.alu_op = (funct3 == F3_ADD_SUB && alt) ? ALU_SUB : f3_op;
                o_uses_rs1    = 1'b1;
                o_uses_rs2    = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = f3_op;
                o_uses_rs1     = 1'b1;
            end
            OPC_LUI: begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = ALU_PASS_B;
                o_imm          = imm_u;
            end
            OPC_LOAD: begin
                // address = rs1 + imm
                o_ctrl.wreg    = 1'b1;
                o_ctrl.load    = 1'b1;
                o_ctrl.use_imm = 1'b1;
                o_uses_rs1     = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.store   = 1'b1;
                o_ctrl.use_imm = 1'b1;
                o_imm          = imm_s;
                o_uses_rs1     = 1'b1;
                o_uses_rs2     = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm      = imm_b;
                o_uses_rs1 = 1'b1;
                o_uses_rs2 = 1'b1;
                if (funct3 == F3_BEQ) begin
                    o_branch_taken = (i_rs1_val == i_rs2_val);
                end else if (funct3 == F3_BNE) begin
                    o_branch_taken = (i_rs1_val != i_rs2_val);
                end
            end
            default: begin
                // treated as nop
                o_ctrl.rd = '0;
            end
        endcase
    end

    assign o_branch_target = i_pc + imm_b;

endmodule

// File: logic/execute_unit.sv
/*
 Execute stage ALU. Shifts use the low five bits of operand b.
*/
`timescale 1ns/1ns

module execute_unit import rv_isa_pkg::*, core_pkg::*; (
    input  id_ex_t          i_ex,
    output logic [XLEN-1:0] o_result
);

    logic [XLEN-1:0] a, b;
    logic [4:0]      shamt;

    assign a     = i_ex.op_a;
    // immediate replaces rs2 for op-imm, lui, lw, sw
    assign b     = i_ex.use_imm ? i_ex.imm : i_ex.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (i_ex.alu_op)
            ALU_ADD:    o_result = a + b;
            ALU_SUB:    o_result = a - b;
            ALU_AND:    o_result = a & b;
            ALU_OR:     o_result = a | b;
            ALU_XOR:    o_result = a ^ b;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, a < b};
            ALU_SLL:    o_result = a << shamt;
            ALU_SRL:    o_result = a >> shamt;
            ALU_SRA:    o_result = $unsigned($signed(a) >>> shamt);
            // lui
            ALU_PASS_B: o_result = b;
            default:    o_result = '0;
        endcase
    end

endmodule

// File: logic/fetch_unit.sv
/*
 PC register. Fetch starts one cycle after reset is released, and
 o_instr_req stays low until then.
*/
`timescale 1ns/1ns

module fetch_unit import rv_isa_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_hold,
    input  logic            i_branch_taken,
    input  logic [XLEN-1:0] i_branch_target,
    output logic [XLEN-1:0] o_pc,
    output logic            o_instr_req
);

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = o_pc + XLEN'(4);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc        <= BOOT_ADDR;
            o_instr_req <= 1'b0;
        end else begin
            o_instr_req <= 1'b1;
            // pc only moves once fetch is live and nothing holds it
            if (o_instr_req && !i_hold) begin
                o_pc <= i_branch_taken ? i_branch_target : pc_plus4;
            end
        end
    end

endmodule

// File: logic/hazard_unit.sv
/*
 Forwarding and pipeline control. All outputs are already qualified
 with the memory freeze, so callers use them as they are.
*/
`timescale 1ns/1ns

module hazard_unit import rv_isa_pkg::*, core_pkg::*; (
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic                  i_uses_rs1,
    input  logic                  i_uses_rs2,
    input  logic [REG_ADDR_W-1:0] i_ex_rd,
    input  logic                  i_ex_wreg,
    input  logic                  i_ex_load,
    input  logic [REG_ADDR_W-1:0] i_mem_rd,
    input  logic                  i_mem_wreg,
    input  logic                  i_mem_load,
    input  logic                  i_branch_taken,
    input  logic                  i_freeze,
    output fwd_sel_e              o_fwd_a,
    output fwd_sel_e              o_fwd_b,
    output logic                  o_stall,
    output logic                  o_flush,
    output logic                  o_run
);

    logic ex_hit_a, ex_hit_b, mem_hit_a, mem_hit_b;
    logic load_use;

    // x0 never forwards
    assign ex_hit_a  = i_uses_rs1 && (i_rs1 != '0) && i_ex_wreg && (i_ex_rd == i_rs1);
    assign ex_hit_b  = i_uses_rs2 && (i_rs2 != '0) && i_ex_wreg && (i_ex_rd == i_rs2);
    assign mem_hit_a = i_uses_rs1 && (i_rs1 != '0) && i_mem_wreg && (i_mem_rd == i_rs1);
    assign mem_hit_b = i_uses_rs2 && (i_rs2 != '0) && i_mem_wreg && (i_mem_rd == i_rs2);

    // youngest producer first, wb comes through the regfile bypass
    assign o_fwd_a = ex_hit_a  ? FWD_EX :
                     mem_hit_a ? (i_mem_load ? FWD_LOAD : FWD_MEM) : FWD_RF;
    assign o_fwd_b = ex_hit_b  ? FWD_EX :
                     mem_hit_b ? (i_mem_load ? FWD_LOAD : FWD_MEM) : FWD_RF;

    // load data not ready until it leaves mem
    assign load_use = i_ex_load && (ex_hit_a || ex_hit_b);

    assign o_run   = !i_freeze;
    assign o_stall = o_run && load_use;
    // branch operands may be stale while stalled, so no redirect then
    assign o_flush = o_run && !load_use && i_branch_taken;

endmodule

// File: logic/lsu.sv
/*
 Data port sequencer, one access at a time. Stores also wait for
 rvalid. o_freeze is high from the issue cycle through the rvalid cycle.
 Byte enables are always all ones since only lw/sw exist.
*/
`timescale 1ns/1ns

module lsu import rv_isa_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_load,
    input  logic            i_store,
    input  logic [XLEN-1:0] i_addr,
    input  logic [XLEN-1:0] i_wdata,
    input  logic            i_data_gnt,
    input  logic            i_data_rvalid,
    input  logic [XLEN-1:0] i_data_rdata,
    output logic            o_data_req,
    output logic            o_data_we,
    output logic [3:0]      o_data_be,
    output logic [XLEN-1:0] o_data_addr,
    output logic [XLEN-1:0] o_data_wdata,
    output logic [XLEN-1:0] o_load_data,
    output logic            o_freeze
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

    state_e state;
    logic   done;
    logic   issue;

    // done blocks a second request while the finished op still sits in mem
    assign issue = (state == ST_IDLE) && (i_load || i_store) && !done;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: if (issue) state <= ST_REQ;
                ST_REQ:  if (i_data_gnt) state <= ST_WAIT;
                ST_WAIT: begin
                    if (i_data_rvalid) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request fields latched once, held until grant
    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_data_addr  <= i_addr;
            o_data_wdata <= i_wdata;
            o_data_we    <= i_store;
        end
        if (state == ST_WAIT && i_data_rvalid && !o_data_we) begin
            o_load_data <= i_data_rdata;
        end
    end

    assign o_data_req = (state == ST_REQ);
    assign o_data_be  = 4'b1111;
    assign o_freeze   = issue || (state != ST_IDLE);

    // bus rule: request stays put until granted, and the frozen mem op still owns it
    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_data_req && !i_data_gnt) |=> (o_data_req && (o_data_addr == i_addr) &&
                                         (o_data_we == i_store) &&
                                         (o_data_wdata == i_wdata)));

endmodule

// File: logic/regfile.sv
/*
 Two read ports, one write port. A write shows on the read ports in
 the same cycle. Reset clears all registers.
*/
`timescale 1ns/1ns

module regfile import rv_isa_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_wdata,
    output logic [XLEN-1:0]       o_rdata1,
    output logic [XLEN-1:0]       o_rdata2
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through bypass, x0 excluded
    assign o_rdata1 = (i_rs1 == '0) ? '0 :
                      (i_we && (i_rd == i_rs1)) ? i_wdata : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 :
                      (i_we && (i_rd == i_rs2)) ? i_wdata : regs[i_rs2];

    // a written value is held in storage for the next read
    a_write_read: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_we && (i_rd != '0)) |=> ((i_rs1 != $past(i_rd)) || (i_we && (i_rd == i_rs1)) ||
                                    (o_rdata1 == $past(i_wdata))));

endmodule

// File: logic/rv_core.sv
/*
 Five-stage RV32I subset core. Instruction memory must answer in the
 same cycle as o_instr_addr. Data port uses req/gnt/rvalid and any wait
 there freezes the whole pipeline.
*/
`timescale 1ns/1ns

module rv_core import rv_isa_pkg::*, core_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  logic            i_clk,
    input  logic            i_rst,
    // instruction port
    output logic            o_instr_req,
    output logic [XLEN-1:0] o_instr_addr,
    input  logic [31:0]     i_instr_rdata,
    // data port
    output logic            o_data_req,
    output logic            o_data_we,
    output logic [3:0]      o_data_be,
    output logic [XLEN-1:0] o_data_addr,
    output logic [XLEN-1:0] o_data_wdata,
    input  logic            i_data_gnt,
    input  logic            i_data_rvalid,
    input  logic [XLEN-1:0] i_data_rdata
);

    localparam if_id_t IF_ID_BUBBLE = '{pc: '0, instr: NOP_INSTR};

    logic [XLEN-1:0]       pc;
    if_id_t                if_id_d, if_id_q;
    id_ex_t                dec_ctrl, id_ex_d, id_ex_q;
    ex_mem_t               ex_mem_d, ex_mem_q;
    mem_wb_t               mem_wb_d, mem_wb_q;
    logic [XLEN-1:0]       imm, br_target, op_a, op_b;
    logic [XLEN-1:0]       rf_rdata1, rf_rdata2, ex_result, load_data;
    logic [REG_ADDR_W-1:0] rs1, rs2;
    logic                  uses_rs1, uses_rs2, br_taken;
    fwd_sel_e              fwd_a, fwd_b;
    logic                  stall, flush, run, freeze;

    // decode operand source
    function automatic logic [XLEN-1:0] fwd_pick(fwd_sel_e sel, logic [XLEN-1:0] rf);
        case (sel)
            FWD_EX:   return ex_result;
            FWD_MEM:  return ex_mem_q.result;
            FWD_LOAD: return load_data;
            default:  return rf;
        endcase
    endfunction

    // fetch
    fetch_unit #(.BOOT_ADDR(BOOT_ADDR)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_hold(stall || !run),
        .i_branch_taken(flush), .i_branch_target(br_target),
        .o_pc(pc), .o_instr_req(o_instr_req)
    );
    assign o_instr_addr = pc;
    // nothing real is fetched before req goes high
    assign if_id_d = o_instr_req ? '{pc: pc, instr: i_instr_rdata} : IF_ID_BUBBLE;

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(run && !stall), .i_flush(flush),
        .i_bubble(IF_ID_BUBBLE), .i_d(if_id_d), .o_q(if_id_q)
    );

    // decode
    decoder u_decoder (
        .i_instr(if_id_q.instr), .i_pc(if_id_q.pc),
        .i_rs1_val(op_a), .i_rs2_val(op_b),
        .o_ctrl(dec_ctrl), .o_imm(imm), .o_rs1(rs1), .o_rs2(rs2),
        .o_uses_rs1(uses_rs1), .o_uses_rs2(uses_rs2),
        .o_branch_taken(br_taken), .o_branch_target(br_target)
    );

    regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1(rs1), .i_rs2(rs2),
        .i_we(mem_wb_q.wreg), .i_rd(mem_wb_q.rd), .i_wdata(mem_wb_q.wdata),
        .o_rdata1(rf_rdata1), .o_rdata2(rf_rdata2)
    );

    hazard_unit u_hazard (
        .i_rs1(rs1), .i_rs2(rs2), .i_uses_rs1(uses_rs1), .i_uses_rs2(uses_rs2),
        .i_ex_rd(id_ex_q.rd), .i_ex_wreg(id_ex_q.wreg), .i_ex_load(id_ex_q.load),
        .i_mem_rd(ex_mem_q.rd), .i_mem_wreg(ex_mem_q.wreg), .i_mem_load(ex_mem_q.load),
        .i_branch_taken(br_taken), .i_freeze(freeze),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall), .o_flush(flush), .o_run(run)
    );

    assign op_a = fwd_pick(fwd_a, rf_rdata1);
    assign op_b = fwd_pick(fwd_b, rf_rdata2);

    always_comb begin
        id_ex_d      = dec_ctrl;
        id_ex_d.op_a = op_a;
        id_ex_d.op_b = op_b;
        id_ex_d.imm  = imm;
    end

    // load-use stall turns the ex slot into a bubble
    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(run), .i_flush(stall),
        .i_bubble('0), .i_d(id_ex_d), .o_q(id_ex_q)
    );

    // execute
    execute_unit u_execute (.i_ex(id_ex_q), .o_result(ex_result));

    assign ex_mem_d = '{result: ex_result, store_data: id_ex_q.op_b, rd: id_ex_q.rd,
                        wreg: id_ex_q.wreg, load: id_ex_q.load, store: id_ex_q.store};

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(run), .i_flush(1'b0),
        .i_bubble('0), .i_d(ex_mem_d), .o_q(ex_mem_q)
    );

    // memory
    lsu u_lsu (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_load(ex_mem_q.load), .i_store(ex_mem_q.store),
        .i_addr(ex_mem_q.result), .i_wdata(ex_mem_q.store_data),
        .i_data_gnt(i_data_gnt), .i_data_rvalid(i_data_rvalid), .i_data_rdata(i_data_rdata),
        .o_data_req(o_data_req), .o_data_we(o_data_we), .o_data_be(o_data_be),
        .o_data_addr(o_data_addr), .o_data_wdata(o_data_wdata),
        .o_load_data(load_data), .o_freeze(freeze)
    );

    // writeback value picked here, wb stage just writes it
    assign mem_wb_d = '{wdata: ex_mem_q.load ? load_data : ex_mem_q.result,
                        rd: ex_mem_q.rd, wreg: ex_mem_q.wreg};

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(run), .i_flush(1'b0),
        .i_bubble('0), .i_d(mem_wb_d), .o_q(mem_wb_q)
    );

endmodule

// File: logic/rv_isa_pkg.sv
/*
 RV32I encodings for the subset this core runs: OP, OP-IMM, LUI,
 LW/SW and BEQ/BNE. Other opcodes decode as no-ops.
*/
package rv_isa_pkg;

    // datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for alu ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // funct3 for branches
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // sub / sra select
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // field positions, lsb of each
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    // addi x0,x0,0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: logic/stage_reg.sv
/*
 Generic pipeline register. Reset and flush both load the bubble
 value, and flush wins over enable.
*/
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_en,
    input  logic     i_flush,
    input  payload_t i_bubble,
    input  payload_t i_d,
    output payload_t o_q
);

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            // squash to a no-op slot
            o_q <= i_bubble;
        end else if (i_en) begin
            o_q <= i_d;
        end
    end

endmodule

// File: sim/tb_rv_core.sv
/*
 Testbench for rv_core. Random program from a fixed seed, checked
 against an in-order model. Data window is 8 words at 0x100, and
 instruction memory answers combinationally from o_instr_addr.
*/
`timescale 1ns/1ns

module tb_rv_core;

    localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
    localparam int          N         = 64;
    localparam int          LIMIT     = N * 12 + 10 + 50;

    logic        clk = 1'b0, rst = 1'b1;
    logic        o_instr_req, o_data_req, o_data_we;
    logic [31:0] o_instr_addr, o_data_addr, o_data_wdata, i_instr_rdata;
    logic [3:0]  o_data_be;
    logic        i_data_gnt = 1'b0, i_data_rvalid = 1'b0;
    logic [31:0] i_data_rdata = '0;

    integer      seed;
    int          kind [N], f3 [N], rd [N], rs1 [N], rs2 [N];
    logic        alt [N];
    logic [31:0] imm [N], imem [N], model_mem [8], bus_mem [8], regs [32];
    logic [31:0] exp_addr [$], exp_data [$];
    logic        exp_we [$];
    logic [31:0] held_addr, held_data, rd_latch;
    logic        held_we, watch = 1'b0, armed = 1'b0, first_seen = 1'b0;
    logic        loop_seen = 1'b0, tail = 1'b0;
    int          gwait = 0, rv_cnt = 0, acc_idx = 0, cycles = 0, i;
    int          err_reset = 0, err_acc = 0, err_stab = 0, err_end = 0;

    rv_core #(.BOOT_ADDR(BOOT_ADDR)) u_rv_core (
        .i_clk(clk), .i_rst(rst),
        .o_instr_req(o_instr_req), .o_instr_addr(o_instr_addr),
        .i_instr_rdata(i_instr_rdata),
        .o_data_req(o_data_req), .o_data_we(o_data_we), .o_data_be(o_data_be),
        .o_data_addr(o_data_addr), .o_data_wdata(o_data_wdata),
        .i_data_gnt(i_data_gnt), .i_data_rvalid(i_data_rvalid), .i_data_rdata(i_data_rdata)
    );

    always #5 clk = ~clk;

    // outside the program the core sees addi x0,x0,0
    assign i_instr_rdata = ((o_instr_addr - BOOT_ADDR) >> 2) < N ?
                           imem[(o_instr_addr - BOOT_ADDR) >> 2] : 32'h0000_0013;

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // initial contents depend on every address bit
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] alu(int f, logic al, logic [31:0] a, logic [31:0] b);
        case (f)
            0: return al ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: return al ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // kinds: 0 reg op, 1 imm op, 2 lui, 3 lw, 4 sw, 5 beq, 6 bne, 7 self-loop
    task automatic gen_program();
        int r, k;
        for (int n = 0; n < N; n++) begin
            r = rand_below(16);
            kind[n] = r < 5 ? 0 : r < 8 ? 1 : r == 8 ? 2 : r < 11 ? 3 : r < 14 ? 4 :
                      r == 14 ? 5 : 6;
            f3[n]  = rand_below(8);
            rd[n]  = 1 + rand_below(7);
            rs1[n] = rand_below(8);
            rs2[n] = rand_below(8);
            alt[n] = 1'b0;
            k      = 2 + rand_below(2);
            if (kind[n] >= 5 && n + k > N - 1) begin
                kind[n] = 0;
            end
            if (n == N - 1) begin
                kind[n] = 7;
            end
            case (kind[n])
                0: begin
                    alt[n] = (f3[n] == 0 || f3[n] == 5) && rand_below(2) == 1;
                    imem[n] = {alt[n] ? 7'h20 : 7'h00, 5'(rs2[n]), 5'(rs1[n]), 3'(f3[n]),
                               5'(rd[n]), 7'h33};
                end
                1: begin
                    if (f3[n] == 1 || f3[n] == 5) begin
                        alt[n] = f3[n] == 5 && rand_below(2) == 1;
                        imm[n] = 32'(rand_below(32));
                    end else begin
                        imm[n] = {{20{1'b0}}, 12'(rand_below(4096))};
                        imm[n] = {{20{imm[n][11]}}, imm[n][11:0]};
                    end
                    imem[n] = {alt[n] ? 7'h20 : 7'h00, imm[n][4:0], 5'(rs1[n]),
                               3'(f3[n]), 5'(rd[n]), 7'h13};
                    if (f3[n] != 1 && f3[n] != 5) begin
                        imem[n][31:20] = imm[n][11:0];
                    end
                end
                2: begin
                    imm[n]  = {12'(rand_below(4096)), 8'(rand_below(256)), 12'h000};
                    imem[n] = {imm[n][31:12], 5'(rd[n]), 7'h37};
                end
                3: begin
                    imm[n]  = 32'h100 + 32'(4 * rand_below(8));
                    imem[n] = {imm[n][11:0], 5'd0, 3'b010, 5'(rd[n]), 7'h03};
                end
                4: begin
                    imm[n]  = 32'h100 + 32'(4 * rand_below(8));
                    imem[n] = {imm[n][11:5], 5'(rs2[n]), 5'd0, 3'b010, imm[n][4:0], 7'h23};
                end
                5, 6: begin
                    imm[n]  = 32'(4 * k);
                    imem[n] = {imm[n][12], imm[n][10:5], 5'(rs2[n]), 5'(rs1[n]),
                               kind[n] == 5 ? 3'b000 : 3'b001, imm[n][4:1], imm[n][11], 7'h63};
                end
                default: imem[n] = 32'h0000_0063;
            endcase
        end
    endtask

    // in-order execution, records every data access
    task automatic run_model();
        int p;
        logic [31:0] v;
        p = 0;
        for (int n = 0; n < 32; n++) begin
            regs[n] = '0;
        end
        while (kind[p] != 7) begin
            case (kind[p])
                0: regs[rd[p]] = alu(f3[p], alt[p], regs[rs1[p]], regs[rs2[p]]);
                1: regs[rd[p]] = alu(f3[p], alt[p], regs[rs1[p]], imm[p]);
                2: regs[rd[p]] = imm[p];
                3: begin
                    v = model_mem[imm[p][4:2]];
                    exp_addr.push_back(imm[p]);
                    exp_we.push_back(1'b0);
                    exp_data.push_back(v);
                    regs[rd[p]] = v;
                end
                default: ;
            endcase
            if (kind[p] == 4) begin
                model_mem[imm[p][4:2]] = regs[rs2[p]];
                exp_addr.push_back(imm[p]);
                exp_we.push_back(1'b1);
                exp_data.push_back(regs[rs2[p]]);
            end
            if ((kind[p] == 5 && regs[rs1[p]] == regs[rs2[p]]) ||
                (kind[p] == 6 && regs[rs1[p]] != regs[rs2[p]])) begin
                p = p + int'(imm[p] >> 2);
            end else begin
                p = p + 1;
            end
        end
    endtask

    // bus observer, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rst && (o_data_req || o_instr_req)) begin
            $display("FAIL o_data_req=%h o_instr_req=%h during reset", o_data_req, o_instr_req);
            err_reset++;
        end
        if (!rst && o_instr_req && !first_seen) begin
            first_seen = 1'b1;
            if (o_instr_addr != BOOT_ADDR) begin
                $display("FAIL o_instr_addr exp %h got %h", BOOT_ADDR, o_instr_addr);
                err_reset++;
            end
        end
        if (!rst && o_instr_addr == BOOT_ADDR + 32'(4 * (N - 1))) begin
            loop_seen = 1'b1;
        end
        if (watch && !(o_data_req && o_data_addr == held_addr && o_data_we == held_we &&
                       o_data_wdata == held_data)) begin
            $display("FAIL o_data_addr/we/wdata moved before grant: %h %h %h -> %h %h %h",
                     held_addr, held_we, held_data, o_data_addr, o_data_we, o_data_wdata);
            err_stab++;
        end
        watch     = o_data_req && !i_data_gnt;
        held_addr = o_data_addr;
        held_we   = o_data_we;
        held_data = o_data_wdata;
        if (tail && o_data_req) begin
            $display("extra data request after the program reached its final loop");
            err_end++;
        end
        if (o_data_req && i_data_gnt && !tail) begin
            if (acc_idx >= exp_addr.size()) begin
                $display("data request beyond the expected access count");
                err_acc++;
            end else begin
                if (o_data_addr != exp_addr[acc_idx]) begin
                    $display("FAIL o_data_addr exp %h got %h", exp_addr[acc_idx], o_data_addr);
                    err_acc++;
                end
                if (o_data_we != exp_we[acc_idx]) begin
                    $display("FAIL o_data_we exp %h got %h", exp_we[acc_idx], o_data_we);
                    err_acc++;
                end
                if (o_data_we && o_data_wdata != exp_data[acc_idx]) begin
                    $display("FAIL o_data_wdata exp %h got %h", exp_data[acc_idx], o_data_wdata);
                    err_acc++;
                end
                if (o_data_be != 4'hf) begin
                    $display("FAIL o_data_be exp %h got %h", 4'hf, o_data_be);
                    err_acc++;
                end
            end
            acc_idx++;
            if (o_data_we) begin
                bus_mem[o_data_addr[4:2]] = o_data_wdata;
            end
            rd_latch = bus_mem[o_data_addr[4:2]];
            armed    = 1'b0;
            rv_cnt   = 1 + rand_below(3);
        end
    end

    // memory responses, driven just after the edge
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles waiting for the program to finish", cycles);
            $display("Done: errors found");
            $finish;
        end
        #1;
        if (o_data_req && !armed) begin
            armed = 1'b1;
            gwait = rand_below(4);
        end
        if (o_data_req && gwait == 0) begin
            i_data_gnt = 1'b1;
        end else begin
            i_data_gnt = 1'b0;
            if (o_data_req) begin
                gwait--;
            end
        end
        i_data_rvalid = 1'b0;
        if (rv_cnt > 0) begin
            rv_cnt--;
            i_data_rvalid = (rv_cnt == 0);
        end
        i_data_rdata = rd_latch;
    end

    initial begin
        seed     = 32'h403e_f68a;
        rd_latch = '0;
        for (i = 0; i < 8; i++) begin
            model_mem[i] = fill_word(32'h100 + 32'(4 * i));
            bus_mem[i]   = model_mem[i];
        end
        gen_program();
        run_model();
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        // first fetch after reset closes the reset checks
        while (!first_seen) begin
            @(posedge clk);
        end
        $display("reset: %0d errors", err_reset);
        while (acc_idx < exp_addr.size() || !loop_seen) begin
            @(posedge clk);
        end
        $display("program accesses: %0d of %0d, %0d errors", acc_idx, exp_addr.size(), err_acc);
        tail = 1'b1;
        repeat (50) @(posedge clk);
        $display("handshake stability: %0d errors", err_stab);
        if (acc_idx != exp_addr.size()) begin
            $display("FAIL access count exp %h got %h", exp_addr.size(), acc_idx);
            err_end++;
        end
        $display("end of program: %0d errors", err_end);
        $display("total errors %0d in %0d cycles", err_reset + err_acc + err_stab + err_end,
                 cycles);
        if (err_reset + err_acc + err_stab + err_end == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
